// ==== Makefile ====
# Verilator build and run for the operand stage testbench

VERILATOR ?= verilator
TOP       ?= operand_stage_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/operand_stage_tb.sv ====
`timescale 1ns/10ps

module operand_stage_tb;

    localparam int DATA_W       = 32;
    localparam int LANES        = DATA_W / 8;
    localparam int AW           = gpr_pkg::REG_ADDR_W;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_TIMEOUT = 10;

    typedef struct packed {
        logic                     ren1;
        logic [AW-1:0]            raddr1;
        logic                     ren2;
        logic [AW-1:0]            raddr2;
        logic [LANES-1:0]         wb_we;
        logic [AW-1:0]            wb_addr;
        logic [LANES-1:0]         ex_wen;
        logic [AW-1:0]            ex_addr;
        logic                     ex_nofwd;
        logic [LANES-1:0]         mem_wen;
        logic [AW-1:0]            mem_addr;
        logic                     mem_nofwd;
        logic                     branch;
        logic                     wb_nofwd;
        logic                     exp_stall;
        hazard_pkg::stall_cause_t exp_cause;
    } row_t;

    logic                     clk;
    logic                     reset;
    logic                     ren1;
    logic                     ren2;
    logic [AW-1:0]            raddr1;
    logic [AW-1:0]            raddr2;
    logic [LANES-1:0]         wb_we;
    logic [AW-1:0]            wb_addr;
    logic [DATA_W-1:0]        wb_data;
    logic [DATA_W-1:0]        wb_data_raw;
    logic [LANES-1:0]         ex_wen;
    logic [AW-1:0]            ex_addr;
    logic [DATA_W-1:0]        ex_data;
    logic                     ex_nofwd;
    logic [LANES-1:0]         mem_wen;
    logic [AW-1:0]            mem_addr;
    logic [DATA_W-1:0]        mem_data;
    logic                     mem_nofwd;
    logic                     inst_wb_nofwd;
    logic                     id_is_branch;
    logic [DATA_W-1:0]        rdata1;
    logic [DATA_W-1:0]        rdata2;
    logic [DATA_W-1:0]        raw_data1;
    logic [DATA_W-1:0]        raw_data2;
    logic                     stall_req;
    hazard_pkg::stall_cause_t stall_cause;

    row_t              rows[$];
    row_t              cur;
    int                row_idx;
    logic [31:0]       lfsr_state = 32'he23bd650;
    logic [DATA_W-1:0] shadow [gpr_pkg::NUM_REGS];

    operand_stage #(.DATA_W(DATA_W)) uut (
        .clk           (clk),
        .reset         (reset),
        .ren1          (ren1),
        .ren2          (ren2),
        .raddr1        (raddr1),
        .raddr2        (raddr2),
        .wb_we         (wb_we),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .wb_data_raw   (wb_data_raw),
        .ex_wen        (ex_wen),
        .ex_addr       (ex_addr),
        .ex_data       (ex_data),
        .ex_nofwd      (ex_nofwd),
        .mem_wen       (mem_wen),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .mem_nofwd     (mem_nofwd),
        .inst_wb_nofwd (inst_wb_nofwd),
        .id_is_branch  (id_is_branch),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .raw_data1     (raw_data1),
        .raw_data2     (raw_data2),
        .stall_req     (stall_req),
        .stall_cause   (stall_cause)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [DATA_W-1:0] rand_word();
        logic [DATA_W-1:0] w;
        w = '0;
        for (int i = 0; i < DATA_W; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[DATA_W-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // expected operand in source order zero, ex, mem, wb lanes, file
    function automatic logic [DATA_W-1:0] expect_operand(input logic [AW-1:0] addr,
                                                          input logic use_ex);
        logic [DATA_W-1:0] v;
        if (addr == '0) begin
            v = '0;
        end else if (use_ex && cur.ex_wen[0] && addr == cur.ex_addr) begin
            v = ex_data;
        end else if (cur.mem_wen[0] && addr == cur.mem_addr) begin
            v = mem_data;
        end else begin
            v = shadow[addr];
            for (int b = 0; b < LANES; b++) begin
                if (addr == cur.wb_addr && cur.wb_we[b]) begin
                    v[b*8 +: 8] = wb_data_raw[b*8 +: 8];
                end
            end
        end
        return v;
    endfunction

    task automatic add_row(input int r1, input int a1, input int r2, input int a2,
                           input int we, input int wa,
                           input int xw, input int xa, input int xn,
                           input int mw, input int ma, input int mn,
                           input int br, input int wn,
                           input int st, input hazard_pkg::stall_cause_t cause);
        row_t r;
        r.ren1      = (r1 != 0);
        r.raddr1    = a1[AW-1:0];
        r.ren2      = (r2 != 0);
        r.raddr2    = a2[AW-1:0];
        r.wb_we     = we[LANES-1:0];
        r.wb_addr   = wa[AW-1:0];
        r.ex_wen    = xw[LANES-1:0];
        r.ex_addr   = xa[AW-1:0];
        r.ex_nofwd  = (xn != 0);
        r.mem_wen   = mw[LANES-1:0];
        r.mem_addr  = ma[AW-1:0];
        r.mem_nofwd = (mn != 0);
        r.branch    = (br != 0);
        r.wb_nofwd  = (wn != 0);
        r.exp_stall = (st != 0);
        r.exp_cause = cause;
        rows.push_back(r);
    endtask

    task automatic drive_idle();
        ren1          = 1'b0;
        ren2          = 1'b0;
        raddr1        = '0;
        raddr2        = '0;
        wb_we         = '0;
        wb_addr       = '0;
        wb_data       = '0;
        wb_data_raw   = '0;
        ex_wen        = '0;
        ex_addr       = '0;
        ex_data       = '0;
        ex_nofwd      = 1'b0;
        mem_wen       = '0;
        mem_addr      = '0;
        mem_data      = '0;
        mem_nofwd     = 1'b0;
        inst_wb_nofwd = 1'b0;
        id_is_branch  = 1'b0;
    endtask

    task automatic apply_row();
        ren1          = cur.ren1;
        ren2          = cur.ren2;
        raddr1        = cur.raddr1;
        raddr2        = cur.raddr2;
        wb_we         = cur.wb_we;
        wb_addr       = cur.wb_addr;
        wb_data       = rand_word();
        wb_data_raw   = rand_word();
        ex_wen        = cur.ex_wen;
        ex_addr       = cur.ex_addr;
        ex_data       = rand_word();
        ex_nofwd      = cur.ex_nofwd;
        mem_wen       = cur.mem_wen;
        mem_addr      = cur.mem_addr;
        mem_data      = rand_word();
        mem_nofwd     = cur.mem_nofwd;
        inst_wb_nofwd = cur.wb_nofwd;
        id_is_branch  = cur.branch;
    endtask

    // mirrors the byte-lane write taken at the coming edge
    task automatic update_shadow();
        for (int b = 0; b < LANES; b++) begin
            if (cur.wb_we[b]) begin
                shadow[cur.wb_addr][b*8 +: 8] = wb_data[b*8 +: 8];
            end
        end
    endtask

    task automatic check(input string name, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] got);
        if (exp !== got) begin
            $display("error %s expected %h got %h (row %0d)", name, exp, got, row_idx);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (stall_req !== 1'b0 || stall_cause !== hazard_pkg::STALL_NONE) begin
            if (cycles == IDLE_TIMEOUT) begin
                $display("stall outputs did not settle to idle after reset");
                $display(">>> FAIL");
                $fatal(1, "timeout after reset");
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    initial begin
        drive_idle();
        reset = 1'b1;
        row_idx = -1;
        for (int r = 0; r < gpr_pkg::NUM_REGS; r++) begin
            shadow[r] = '0;
        end

        // row columns ren1 a1 ren2 a2 | wb_we wb_a | ex wen a nofwd | mem wen a nofwd
        //          | branch wb_nofwd | stall cause
        // every register reads zero after reset
        for (int r = 0; r < 16; r++) begin
            add_row(1, r, 1, 31 - r, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                    0, hazard_pkg::STALL_NONE);
        end
        // byte-lane writes with some lanes off
        add_row(0, 0, 0, 0, 'hf, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(0, 0, 0, 0, 'h5, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 5, 0, 0, 'h2, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(0, 0, 0, 0, 'h8, 12, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(0, 0, 0, 0, 'hf, 31, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 5, 1, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 12, 1, 31, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        // register 0 is written but reads zero
        add_row(0, 0, 0, 0, 'hf, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 0, 1, 0, 'hf, 0, 1, 0, 1, 1, 0, 1, 1, 1, 0, hazard_pkg::STALL_NONE);
        // forwarding priority with producers removed one at a time
        add_row(1, 7, 1, 5, 'hf, 7, 1, 7, 0, 1, 7, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 7, 0, 0, 'h3, 7, 0, 0, 0, 1, 7, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 7, 0, 0, 'hc, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        // ex enable without bit 0 is not a register write
        add_row(1, 7, 0, 0, 0, 0, 'he, 7, 1, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        // partial write-back merge on port 2
        add_row(0, 0, 1, 12, 'h3, 12, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        // each stall cause alone on either port
        add_row(1, 9, 0, 0, 0, 0, 1, 9, 1, 0, 0, 0, 0, 0, 1, hazard_pkg::STALL_EX_LATE);
        add_row(0, 0, 1, 9, 0, 0, 1, 9, 1, 0, 0, 0, 0, 0, 1, hazard_pkg::STALL_EX_LATE);
        add_row(0, 0, 1, 10, 0, 0, 0, 0, 0, 1, 10, 1, 0, 0, 1, hazard_pkg::STALL_MEM_LATE);
        add_row(1, 10, 0, 0, 0, 0, 0, 0, 0, 1, 10, 1, 0, 0, 1, hazard_pkg::STALL_MEM_LATE);
        add_row(1, 9, 0, 0, 0, 0, 1, 9, 0, 0, 0, 0, 1, 0, 1, hazard_pkg::STALL_BRANCH);
        add_row(0, 0, 1, 9, 0, 0, 1, 9, 0, 0, 0, 0, 1, 0, 1, hazard_pkg::STALL_BRANCH);
        add_row(0, 0, 1, 12, 'h4, 12, 0, 0, 0, 0, 0, 0, 0, 1, 1, hazard_pkg::STALL_WB_DEP);
        add_row(1, 12, 0, 0, 'h4, 12, 0, 0, 0, 0, 0, 0, 0, 1, 1, hazard_pkg::STALL_WB_DEP);
        // combined causes
        add_row(1, 9, 1, 10, 0, 0, 1, 9, 1, 1, 10, 1, 0, 0, 1, hazard_pkg::STALL_EX_LATE);
        add_row(1, 9, 1, 10, 0, 0, 1, 9, 0, 1, 10, 1, 1, 0, 1, hazard_pkg::STALL_MEM_LATE);
        add_row(1, 9, 1, 12, 'h1, 12, 1, 9, 0, 0, 0, 0, 1, 1, 1, hazard_pkg::STALL_BRANCH);
        add_row(1, 9, 1, 9, 'hf, 9, 1, 9, 1, 1, 9, 1, 1, 1, 1, hazard_pkg::STALL_EX_LATE);
        // no stall with read enable low or address 0 or forwardable producers
        add_row(0, 9, 0, 10, 'hf, 10, 1, 9, 1, 1, 10, 1, 1, 1, 0, hazard_pkg::STALL_NONE);
        add_row(1, 0, 1, 0, 0, 0, 1, 0, 1, 1, 0, 1, 1, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 9, 0, 0, 0, 0, 'he, 9, 1, 0, 0, 0, 1, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 12, 0, 0, 0, 12, 0, 0, 0, 0, 0, 0, 0, 1, 0, hazard_pkg::STALL_NONE);
        add_row(1, 9, 0, 0, 0, 0, 1, 9, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(0, 0, 1, 10, 0, 0, 0, 0, 0, 1, 10, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 12, 0, 0, 'h4, 12, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);
        add_row(1, 9, 1, 10, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, hazard_pkg::STALL_NONE);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_idle();

        foreach (rows[i]) begin
            row_idx = i;
            cur = rows[i];
            @(negedge clk);
            apply_row();
            // sample just before the next rising edge
            #(CLK_PERIOD / 2 - 1);
            check("rdata1", expect_operand(cur.raddr1, 1'b1), rdata1);
            check("rdata2", expect_operand(cur.raddr2, 1'b1), rdata2);
            check("raw_data1", expect_operand(cur.raddr1, 1'b0), raw_data1);
            check("raw_data2", expect_operand(cur.raddr2, 1'b0), raw_data2);
            check("stall_req", 32'(cur.exp_stall), 32'(stall_req));
            check("stall_cause", 32'(cur.exp_cause), 32'(stall_cause));
            update_shadow();
        end

        @(negedge clk);
        drive_idle();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/gpr_pkg.sv
verilog/hazard_pkg.sv
verilog/gpr_file.sv
verilog/hazard_ctrl.sv
verilog/operand_select.sv
verilog/operand_stage.sv
verif/operand_stage_tb.sv

// ==== verilog/gpr_file.sv ====
`timescale 1ns/10ps

module gpr_file #(
    parameter int DATA_W = 32,
    localparam int LANES = DATA_W / 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [LANES-1:0]               wb_we,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [DATA_W-1:0]              wb_data,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [DATA_W-1:0]              file_data1,
    output logic [DATA_W-1:0]              file_data2
);

    logic [DATA_W-1:0] regs [gpr_pkg::NUM_REGS];

    // byte-lane write
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < gpr_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < LANES; b++) begin
                if (wb_we[b]) begin
                    regs[wb_addr][b*8 +: 8] <= wb_data[b*8 +: 8];
                end
            end
        end
    end

    // raw contents, register 0 included
    // the zero for address 0 is chosen by the operand select
    assign file_data1 = regs[raddr1];
    assign file_data2 = regs[raddr2];

endmodule

// ==== verilog/gpr_pkg.sv ====
package gpr_pkg;

    // register file geometry
    parameter int REG_ADDR_W = 5;
    parameter int NUM_REGS   = 32;

    // where one operand is taken from
    typedef enum logic [2:0] {
        // register 0 reads as zero
        FWD_ZERO = 3'd0,
        // execute result
        FWD_EX   = 3'd1,
        // memory result
        FWD_MEM  = 3'd2,
        // write-back lanes merged over the stored word
        FWD_WB   = 3'd3,
        // stored register
        FWD_FILE = 3'd4
    } fwd_src_t;

endpackage

// ==== verilog/hazard_ctrl.sv ====
`timescale 1ns/10ps

module hazard_ctrl #(
    parameter int DATA_W = 32,
    localparam int LANES = DATA_W / 8
) (
    input  logic                           ren1,
    input  logic                           ren2,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] raddr2,
    input  logic [LANES-1:0]               wb_we,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [LANES-1:0]               ex_wen,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] ex_addr,
    input  logic                           ex_nofwd,
    input  logic [LANES-1:0]               mem_wen,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] mem_addr,
    input  logic                           mem_nofwd,
    input  logic                           inst_wb_nofwd,
    input  logic                           id_is_branch,
    output gpr_pkg::fwd_src_t              full_sel1,
    output gpr_pkg::fwd_src_t              full_sel2,
    output gpr_pkg::fwd_src_t              raw_sel1,
    output gpr_pkg::fwd_src_t              raw_sel2,
    output logic [LANES-1:0]               wb_lane_hit1,
    output logic [LANES-1:0]               wb_lane_hit2,
    output logic                           stall_req,
    output hazard_pkg::stall_cause_t       stall_cause
);

    logic zero1;
    logic zero2;
    logic ex_hit1;
    logic ex_hit2;
    logic mem_hit1;
    logic mem_hit2;
    logic wb_hit1;
    logic wb_hit2;
    logic reading1;
    logic reading2;

    logic ex_dep;
    logic mem_dep;
    logic wb_dep;

    logic ex_late;
    logic mem_late;
    logic branch_dep;
    logic wb_extra;

    // priority: zero, ex, mem, wb, file
    function automatic gpr_pkg::fwd_src_t pick_src(
        input logic addr_zero,
        input logic ex_hit,
        input logic mem_hit,
        input logic wb_hit
    );
        gpr_pkg::fwd_src_t src;
        if (addr_zero) begin
            src = gpr_pkg::FWD_ZERO;
        end else if (ex_hit) begin
            src = gpr_pkg::FWD_EX;
        end else if (mem_hit) begin
            src = gpr_pkg::FWD_MEM;
        end else if (wb_hit) begin
            src = gpr_pkg::FWD_WB;
        end else begin
            src = gpr_pkg::FWD_FILE;
        end
        return src;
    endfunction

    assign zero1 = (raddr1 == '0);
    assign zero2 = (raddr2 == '0);

    // only bit 0 of the ex/mem enables means a register write
    assign ex_hit1  = ex_wen[0] && (raddr1 == ex_addr);
    assign ex_hit2  = ex_wen[0] && (raddr2 == ex_addr);
    assign mem_hit1 = mem_wen[0] && (raddr1 == mem_addr);
    assign mem_hit2 = mem_wen[0] && (raddr2 == mem_addr);

    // per-lane write-back hits
    assign wb_lane_hit1 = (raddr1 == wb_addr) ? wb_we : '0;
    assign wb_lane_hit2 = (raddr2 == wb_addr) ? wb_we : '0;
    assign wb_hit1      = |wb_lane_hit1;
    assign wb_hit2      = |wb_lane_hit2;

    assign full_sel1 = pick_src(zero1, ex_hit1, mem_hit1, wb_hit1);
    assign full_sel2 = pick_src(zero2, ex_hit2, mem_hit2, wb_hit2);

    // branch compare path never sees execute
    assign raw_sel1 = pick_src(zero1, 1'b0, mem_hit1, wb_hit1);
    assign raw_sel2 = pick_src(zero2, 1'b0, mem_hit2, wb_hit2);

    assign reading1 = ren1 && !zero1;
    assign reading2 = ren2 && !zero2;

    assign ex_dep  = (reading1 && ex_hit1) || (reading2 && ex_hit2);
    assign mem_dep = (reading1 && mem_hit1) || (reading2 && mem_hit2);
    assign wb_dep  = (reading1 && wb_hit1) || (reading2 && wb_hit2);

    assign ex_late    = ex_dep && ex_nofwd;
    assign mem_late   = mem_dep && mem_nofwd;
    assign branch_dep = id_is_branch && ex_dep;
    assign wb_extra   = inst_wb_nofwd && wb_dep;

    assign stall_req = ex_late || mem_late || branch_dep || wb_extra;

    always_comb begin
        if (ex_late) begin
            stall_cause = hazard_pkg::STALL_EX_LATE;
        end else if (mem_late) begin
            stall_cause = hazard_pkg::STALL_MEM_LATE;
        end else if (branch_dep) begin
            stall_cause = hazard_pkg::STALL_BRANCH;
        end else if (wb_extra) begin
            stall_cause = hazard_pkg::STALL_WB_DEP;
        end else begin
            stall_cause = hazard_pkg::STALL_NONE;
        end
    end

endmodule

// ==== verilog/hazard_pkg.sv ====
package hazard_pkg;

    // why decode is held, first matching rule wins
    typedef enum logic [2:0] {
        STALL_NONE     = 3'd0,
        // execute producer has no result yet
        STALL_EX_LATE  = 3'd1,
        // memory producer has no result yet
        STALL_MEM_LATE = 3'd2,
        // branch compare depends on execute
        STALL_BRANCH   = 3'd3,
        // instruction wants an extra cycle after a write-back dependence
        STALL_WB_DEP   = 3'd4
    } stall_cause_t;

endpackage

// ==== verilog/operand_select.sv ====
`timescale 1ns/10ps

module operand_select #(
    parameter int DATA_W = 32,
    localparam int LANES = DATA_W / 8
) (
    input  logic [DATA_W-1:0] file_data,
    input  logic [DATA_W-1:0] wb_data_raw,
    input  logic [LANES-1:0]  wb_lane_hit,
    input  logic [DATA_W-1:0] ex_data,
    input  logic [DATA_W-1:0] mem_data,
    input  gpr_pkg::fwd_src_t full_sel,
    input  gpr_pkg::fwd_src_t raw_sel,
    output logic [DATA_W-1:0] operand,
    output logic [DATA_W-1:0] raw_operand
);

    logic [DATA_W-1:0] wb_view;

    // write-back lanes over the stored word
    always_comb begin
        for (int b = 0; b < LANES; b++) begin
            if (wb_lane_hit[b]) begin
                wb_view[b*8 +: 8] = wb_data_raw[b*8 +: 8];
            end else begin
                wb_view[b*8 +: 8] = file_data[b*8 +: 8];
            end
        end
    end

    always_comb begin
        case (full_sel)
            gpr_pkg::FWD_ZERO: operand = '0;
            gpr_pkg::FWD_EX:   operand = ex_data;
            gpr_pkg::FWD_MEM:  operand = mem_data;
            gpr_pkg::FWD_WB:   operand = wb_view;
            default:           operand = file_data;
        endcase
    end

    // raw_sel never carries FWD_EX
    always_comb begin
        case (raw_sel)
            gpr_pkg::FWD_ZERO: raw_operand = '0;
            gpr_pkg::FWD_MEM:  raw_operand = mem_data;
            gpr_pkg::FWD_WB:   raw_operand = wb_view;
            default:           raw_operand = file_data;
        endcase
    end

endmodule

// ==== verilog/operand_stage.sv ====
`timescale 1ns/10ps

module operand_stage #(
    parameter int DATA_W = 32,
    localparam int LANES = DATA_W / 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ren1,
    input  logic                           ren2,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] raddr2,
    input  logic [LANES-1:0]               wb_we,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [DATA_W-1:0]              wb_data,
    input  logic [DATA_W-1:0]              wb_data_raw,
    input  logic [LANES-1:0]               ex_wen,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] ex_addr,
    input  logic [DATA_W-1:0]              ex_data,
    input  logic                           ex_nofwd,
    input  logic [LANES-1:0]               mem_wen,
    input  logic [gpr_pkg::REG_ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0]              mem_data,
    input  logic                           mem_nofwd,
    input  logic                           inst_wb_nofwd,
    input  logic                           id_is_branch,
    output logic [DATA_W-1:0]              rdata1,
    output logic [DATA_W-1:0]              rdata2,
    output logic [DATA_W-1:0]              raw_data1,
    output logic [DATA_W-1:0]              raw_data2,
    output logic                           stall_req,
    output hazard_pkg::stall_cause_t       stall_cause
);

    logic [DATA_W-1:0] file_data1;
    logic [DATA_W-1:0] file_data2;
    gpr_pkg::fwd_src_t full_sel1;
    gpr_pkg::fwd_src_t full_sel2;
    gpr_pkg::fwd_src_t raw_sel1;
    gpr_pkg::fwd_src_t raw_sel2;
    logic [LANES-1:0]  wb_lane_hit1;
    logic [LANES-1:0]  wb_lane_hit2;

    gpr_file #(.DATA_W(DATA_W)) regs (
        .clk        (clk),
        .reset      (reset),
        .wb_we      (wb_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .file_data1 (file_data1),
        .file_data2 (file_data2)
    );

    hazard_ctrl #(.DATA_W(DATA_W)) ctrl (
        .ren1          (ren1),
        .ren2          (ren2),
        .raddr1        (raddr1),
        .raddr2        (raddr2),
        .wb_we         (wb_we),
        .wb_addr       (wb_addr),
        .ex_wen        (ex_wen),
        .ex_addr       (ex_addr),
        .ex_nofwd      (ex_nofwd),
        .mem_wen       (mem_wen),
        .mem_addr      (mem_addr),
        .mem_nofwd     (mem_nofwd),
        .inst_wb_nofwd (inst_wb_nofwd),
        .id_is_branch  (id_is_branch),
        .full_sel1     (full_sel1),
        .full_sel2     (full_sel2),
        .raw_sel1      (raw_sel1),
        .raw_sel2      (raw_sel2),
        .wb_lane_hit1  (wb_lane_hit1),
        .wb_lane_hit2  (wb_lane_hit2),
        .stall_req     (stall_req),
        .stall_cause   (stall_cause)
    );

    // read port 1
    operand_select #(.DATA_W(DATA_W)) sel1 (
        .file_data   (file_data1),
        .wb_data_raw (wb_data_raw),
        .wb_lane_hit (wb_lane_hit1),
        .ex_data     (ex_data),
        .mem_data    (mem_data),
        .full_sel    (full_sel1),
        .raw_sel     (raw_sel1),
        .operand     (rdata1),
        .raw_operand (raw_data1)
    );

    // read port 2
    operand_select #(.DATA_W(DATA_W)) sel2 (
        .file_data   (file_data2),
        .wb_data_raw (wb_data_raw),
        .wb_lane_hit (wb_lane_hit2),
        .ex_data     (ex_data),
        .mem_data    (mem_data),
        .full_sel    (full_sel2),
        .raw_sel     (raw_sel2),
        .operand     (rdata2),
        .raw_operand (raw_data2)
    );

endmodule
